//--- rtl/mmu_defs.svh
`ifndef MMU_DEFS_SVH
`define MMU_DEFS_SVH

// number of fully associative translation entries
`define MMU_TLB_ENTRIES 8

// 4 KiB pages
`define MMU_PAGE_SHIFT 12

// satp.MODE value selecting Sv39
`define MMU_SATP_MODE_SV39 8

// Sv39 walks levels 2, 1 and 0
`define MMU_PTW_LEVELS 3

// width of one VPN slice per level
`define MMU_VPN_BITS 9

`endif

//--- rtl/mmu_pkg.sv
`default_nettype none

`include "mmu_defs.svh"

package mmu_pkg;

    typedef logic [7:0] rqst_id_t;  // 0 means no request

    typedef logic [63:0] vaddr_t;
    typedef logic [63:0] paddr_t;

    typedef logic [`MMU_PTW_LEVELS*`MMU_VPN_BITS-1:0] vpn_t;  // vadd[38:12]
    typedef logic [43:0] ppn_t;
    typedef logic [7:0] perm_t;  // D A G U X W R V
    typedef logic [63:0] pte_t;  // also used for satp

    // walker states
    typedef enum logic [2:0] {
        ptw_idle,      // waiting for a miss
        ptw_addr,      // issue the memory read for the current level
        ptw_wait_mem,  // memory read outstanding
        ptw_check,     // decode the returned PTE
        ptw_done       // result valid for one cycle
    } ptw_state_e;

endpackage

`default_nettype wire

//--- rtl/tlb_lookup_stage.sv
`default_nettype none

`include "mmu_defs.svh"

module tlb_lookup_stage import mmu_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  rqst_id_t                    rqst,
    input  vaddr_t                      vadd,
    input  pte_t                        satp,
    input  rqst_id_t                    resp,
    output logic                        lookup,
    output rqst_id_t                    pend_id,
    output vpn_t                        pend_vpn,
    output logic [`MMU_PAGE_SHIFT-1:0]  pend_ofst,
    output pte_t                        pend_satp,
    input  logic                        fence
);

    always_ff @(posedge clk) begin
        if (rst) begin
            lookup  <= 1'b0;
            pend_id <= '0;
        end else begin
            lookup <= |rqst;  // entries compare in the cycle after capture
            if (|rqst) begin
                pend_id <= rqst;
            end else if (|resp && resp == pend_id) begin
                pend_id <= '0;  // answered
            end
        end
    end

    always_ff @(posedge clk) begin
        if (|rqst) begin
            pend_vpn  <= vadd[`MMU_PAGE_SHIFT +: $bits(vpn_t)];
            pend_ofst <= vadd[`MMU_PAGE_SHIFT-1:0];
            pend_satp <= satp;
        end
    end

    // requester keeps a single request in flight
    a_one_pending: assert property (@(posedge clk) disable iff (rst)
        |rqst |-> (pend_id == '0 || resp == pend_id));

    // a fence during a walk would race the refill
    a_fence_idle: assert property (@(posedge clk) disable iff (rst)
        fence |-> (pend_id == '0 || resp == pend_id));

endmodule

`default_nettype wire

//--- rtl/tlb_entry.sv
`default_nettype none

module tlb_entry import mmu_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  fence,
    input  vpn_t  lookup_vpn,
    input  logic  refill_en,
    input  logic  refill_idx_match,
    input  vpn_t  refill_vpn,
    input  ppn_t  refill_ppn,
    input  perm_t refill_perm,
    output logic  hit,
    output ppn_t  ppn,
    output perm_t perm
);

    logic valid;
    vpn_t vpn;
    logic load;

    assign load = refill_en && refill_idx_match;

    always_ff @(posedge clk) begin
        if (rst || fence) begin
            valid <= 1'b0;  // sfence.vma drops every entry
        end else if (load) begin
            valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            vpn  <= refill_vpn;
            ppn  <= refill_ppn;
            perm <= refill_perm;
        end
    end

    assign hit = valid && (vpn == lookup_vpn);

endmodule

`default_nettype wire

//--- rtl/tlb_response_merge.sv
`default_nettype none

`include "mmu_defs.svh"

module tlb_response_merge import mmu_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        lookup,
    input  rqst_id_t                    pend_id,
    input  logic [`MMU_PAGE_SHIFT-1:0]  pend_ofst,
    input  logic [`MMU_TLB_ENTRIES-1:0] hit_vec,
    input  ppn_t                        ppn_vec [`MMU_TLB_ENTRIES],
    input  perm_t                       perm_vec [`MMU_TLB_ENTRIES],
    input  logic                        walk_done,
    input  ppn_t                        walk_ppn,
    input  perm_t                       walk_perm,
    input  logic                        walk_fault,
    output logic                        miss,
    output rqst_id_t                    resp,
    output perm_t                       perm,
    output paddr_t                      padd,
    output logic                        fault
);

    logic  any_hit;
    ppn_t  sel_ppn;
    perm_t sel_perm;

    // and-or mux, hit_vec is one-hot
    always_comb begin
        sel_ppn  = '0;
        sel_perm = '0;
        for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
            if (hit_vec[i]) begin
                sel_ppn  |= ppn_vec[i];
                sel_perm |= perm_vec[i];
            end
        end
    end

    assign any_hit = |hit_vec;
    assign miss    = lookup && !any_hit;  // starts the walker

    always_ff @(posedge clk) begin
        if (rst) begin
            resp <= '0;
        end else if ((lookup && any_hit) || walk_done) begin
            resp <= pend_id;
        end else begin
            resp <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup && any_hit) begin
            padd  <= paddr_t'({sel_ppn, pend_ofst});
            perm  <= sel_perm;
            fault <= 1'b0;
        end else if (walk_done) begin
            padd  <= walk_fault ? '0 : paddr_t'({walk_ppn, pend_ofst});
            perm  <= walk_fault ? '0 : walk_perm;
            fault <= walk_fault;
        end
    end

    // refill always takes a fresh slot, so duplicates mean a broken miss path
    a_single_hit: assert property (@(posedge clk) disable iff (rst)
        lookup |-> $onehot0(hit_vec));

endmodule

`default_nettype wire

//--- rtl/page_table_walker.sv
`default_nettype none

`include "mmu_defs.svh"

module page_table_walker import mmu_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        miss,
    input  vpn_t                        pend_vpn,
    input  pte_t                        pend_satp,
    input  logic                        mem_resp,
    input  pte_t                        mem_rdata,
    output logic                        mem_req,
    output paddr_t                      mem_addr,
    output logic                        walk_done,
    output ppn_t                        walk_ppn,
    output perm_t                       walk_perm,
    output logic                        walk_fault,
    output logic                        refill_en,
    output logic [`MMU_TLB_ENTRIES-1:0] refill_sel,
    output vpn_t                        refill_vpn,
    output ppn_t                        refill_ppn,
    output perm_t                       refill_perm
);

    localparam int IDX_W = $clog2(`MMU_TLB_ENTRIES);

    ptw_state_e             state;
    logic [1:0]             level;
    ppn_t                   cur_ppn;  // table base for the current level
    pte_t                   pte;
    logic [IDX_W-1:0]       rr_ptr;   // next victim
    logic [`MMU_VPN_BITS-1:0] vpn_slice;
    logic                   pte_leaf;
    logic                   pte_bad;

    assign vpn_slice = pend_vpn[level*`MMU_VPN_BITS +: `MMU_VPN_BITS];

    always_comb begin
        pte_leaf = pte[1] || pte[3];  // R or X set
        pte_bad  = !pte[0]                       // not valid
                || (pte[2] && !pte[1])           // W without R
                || (pte_leaf && level != 2'd0)   // superpages not supported
                || (!pte_leaf && level == 2'd0); // pointer past last level
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ptw_idle;
            mem_req    <= 1'b0;
            walk_fault <= 1'b0;
            rr_ptr     <= '0;
        end else begin
            mem_req <= 1'b0;
            case (state)
                ptw_idle: if (miss) begin
                    cur_ppn <= pend_satp[43:0];
                    level   <= 2'(`MMU_PTW_LEVELS - 1);
                    if (pend_satp[63:60] == 4'(`MMU_SATP_MODE_SV39)) begin
                        walk_fault <= 1'b0;
                        state      <= ptw_addr;
                    end else begin
                        walk_fault <= 1'b1;  // bare or unsupported mode
                        state      <= ptw_done;
                    end
                end
                ptw_addr: begin
                    mem_req  <= 1'b1;
                    mem_addr <= paddr_t'({cur_ppn, {`MMU_PAGE_SHIFT{1'b0}}})
                              + paddr_t'({vpn_slice, 3'b000});
                    state    <= ptw_wait_mem;
                end
                ptw_wait_mem: if (mem_resp) begin
                    pte   <= mem_rdata;
                    state <= ptw_check;
                end
                ptw_check: begin
                    if (pte_bad) begin
                        walk_fault <= 1'b1;
                        state      <= ptw_done;
                    end else if (pte_leaf) begin
                        walk_ppn  <= pte[53:10];
                        walk_perm <= pte[7:0];
                        state     <= ptw_done;
                    end else begin
                        cur_ppn <= pte[53:10];  // descend one level
                        level   <= level - 2'd1;
                        state   <= ptw_addr;
                    end
                end
                ptw_done: begin
                    if (!walk_fault) begin
                        rr_ptr <= (rr_ptr == IDX_W'(`MMU_TLB_ENTRIES - 1)) ? '0 : rr_ptr + 1'b1;
                    end
                    state <= ptw_idle;
                end
                default: state <= ptw_idle;
            endcase
        end
    end

    assign walk_done   = (state == ptw_done);
    assign refill_en   = walk_done && !walk_fault;
    assign refill_sel  = `MMU_TLB_ENTRIES'(1) << rr_ptr;
    assign refill_vpn  = pend_vpn;  // held by the lookup stage for the whole walk
    assign refill_ppn  = walk_ppn;
    assign refill_perm = walk_perm;

    // memory answers only the read we issued
    a_resp_in_wait: assert property (@(posedge clk) disable iff (rst)
        mem_resp |-> state == ptw_wait_mem);

endmodule

`default_nettype wire

//--- rtl/mmu_tlb.sv
`default_nettype none

`include "mmu_defs.svh"

module mmu_tlb import mmu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  rqst_id_t rqst,
    input  vaddr_t   vadd,
    input  pte_t     satp,
    output rqst_id_t resp,
    output perm_t    perm,
    output paddr_t   padd,
    output logic     fault,
    input  logic     fence,     // sfence.vma, flushes everything
    output logic     mem_req,
    output paddr_t   mem_addr,
    input  logic     mem_resp,
    input  pte_t     mem_rdata
);

    logic                        lookup;
    rqst_id_t                    pend_id;
    vpn_t                        pend_vpn;
    logic [`MMU_PAGE_SHIFT-1:0]  pend_ofst;
    pte_t                        pend_satp;
    logic                        miss;
    logic [`MMU_TLB_ENTRIES-1:0] hit_vec;
    ppn_t                        ppn_vec [`MMU_TLB_ENTRIES];
    perm_t                       perm_vec [`MMU_TLB_ENTRIES];
    logic                        walk_done;
    ppn_t                        walk_ppn;
    perm_t                       walk_perm;
    logic                        walk_fault;
    logic                        refill_en;
    logic [`MMU_TLB_ENTRIES-1:0] refill_sel;
    vpn_t                        refill_vpn;
    ppn_t                        refill_ppn;
    perm_t                       refill_perm;

    tlb_lookup_stage u_lookup (
        .clk(clk), .rst(rst), .rqst(rqst), .vadd(vadd), .satp(satp), .resp(resp),
        .lookup(lookup), .pend_id(pend_id), .pend_vpn(pend_vpn),
        .pend_ofst(pend_ofst), .pend_satp(pend_satp), .fence(fence)
    );

    for (genvar i = 0; i < `MMU_TLB_ENTRIES; i++) begin : g_entry
        tlb_entry u_entry (
            .clk(clk), .rst(rst), .fence(fence), .lookup_vpn(pend_vpn),
            .refill_en(refill_en), .refill_idx_match(refill_sel[i]),
            .refill_vpn(refill_vpn), .refill_ppn(refill_ppn), .refill_perm(refill_perm),
            .hit(hit_vec[i]), .ppn(ppn_vec[i]), .perm(perm_vec[i])
        );
    end

    tlb_response_merge u_merge (
        .clk(clk), .rst(rst), .lookup(lookup), .pend_id(pend_id), .pend_ofst(pend_ofst),
        .hit_vec(hit_vec), .ppn_vec(ppn_vec), .perm_vec(perm_vec),
        .walk_done(walk_done), .walk_ppn(walk_ppn), .walk_perm(walk_perm),
        .walk_fault(walk_fault), .miss(miss), .resp(resp), .perm(perm),
        .padd(padd), .fault(fault)
    );

    page_table_walker u_ptw (
        .clk(clk), .rst(rst), .miss(miss), .pend_vpn(pend_vpn), .pend_satp(pend_satp),
        .mem_resp(mem_resp), .mem_rdata(mem_rdata), .mem_req(mem_req),
        .mem_addr(mem_addr), .walk_done(walk_done), .walk_ppn(walk_ppn),
        .walk_perm(walk_perm), .walk_fault(walk_fault), .refill_en(refill_en),
        .refill_sel(refill_sel), .refill_vpn(refill_vpn), .refill_ppn(refill_ppn),
        .refill_perm(refill_perm)
    );

endmodule

`default_nettype wire

//--- sim/mmu_checker.sv
`default_nettype none

module mmu_checker (
    input logic        clk,
    input logic        rst,
    input logic [7:0]  rqst,
    input logic [7:0]  resp,
    input logic [7:0]  perm,
    input logic [63:0] padd,
    input logic        fault,
    input logic        mem_req
);
    timeunit 1ns;
    timeprecision 100ps;

    string       exp_name;
    logic [7:0]  exp_id;
    logic [63:0] exp_padd;
    logic [7:0]  exp_perm;
    logic        exp_fault;
    int          exp_reads;
    int          reads;         // mem_req pulses seen for the current test
    int          cycles;        // edges since the request was sampled
    logic        active;
    int          checked = 0;
    int          fail_count = 0;

    task automatic expect_test(input string name, input logic [7:0] id, input logic [63:0] pa,
                               input logic [7:0] pm, input logic flt, input int rd);
        exp_name  = name;
        exp_id    = id;
        exp_padd  = pa;
        exp_perm  = pm;
        exp_fault = flt;
        exp_reads = rd;
    endtask

    task automatic mismatch(input string what, input logic [63:0] exp, input logic [63:0] act);
        $display("** Error: %s: %s expected %h, actual %h", exp_name, what, exp, act);
        fail_count++;
    endtask

    task automatic check_response();
        checked++;
        if (!active) begin
            $display("response with ID %0d arrived while no request was outstanding", resp);
            fail_count++;
        end else if (resp != exp_id)
            mismatch("resp id", 64'(exp_id), 64'(resp));
        else if (padd != exp_padd)
            mismatch("padd", exp_padd, padd);
        else if (perm != exp_perm)
            mismatch("perm", 64'(exp_perm), 64'(perm));
        else if (fault != exp_fault)
            mismatch("fault", 64'(exp_fault), 64'(fault));
        else if (reads != exp_reads)
            mismatch("memory reads", 64'(exp_reads), 64'(reads));
        else if (exp_reads == 0 && !exp_fault && cycles + 1 != 2)
            mismatch("hit latency", 64'd2, 64'(cycles + 1));  // hit answers 2 cycles after rqst
        else
            $display("ok    %s", exp_name);
    endtask

    task automatic report_counts();
        $display("%0d tests checked, %0d ok, %0d failed", checked, checked - fail_count,
                 fail_count);
    endtask

    always @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
        end else if (|rqst) begin
            active <= 1'b1;
            reads  <= 0;
            cycles <= 0;
        end else if (|resp) begin
            check_response();
            active <= 1'b0;
        end else if (active) begin
            cycles <= cycles + 1;
            if (mem_req) reads <= reads + 1;  // one pulse per walk level
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_mmu.sv
`default_nettype none

module tb_mmu;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_TESTS = 17;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 40;
    localparam logic [63:0] SATP_SV39 = {4'd8, 16'd0, 44'h80000};  // root at 0x8000_0000
    localparam logic [63:0] SATP_BARE = {4'd0, 16'd0, 44'h80000};

    logic        clk;
    logic        rst;
    logic [7:0]  rqst;
    logic [63:0] vadd;
    logic [63:0] satp;
    logic        fence;
    logic [7:0]  resp;
    logic [7:0]  perm;
    logic [63:0] padd;
    logic        fault;
    logic        mem_req;
    logic [63:0] mem_addr;
    logic        mem_resp;
    logic [63:0] mem_rdata;

    integer      seed = 32'h0889280c;
    int          mem_wait;
    logic [63:0] mem_base;
    int          cycle_count = 0;
    int          n_rows = 0;

    string       t_name  [NUM_TESTS];
    logic [63:0] t_vadd  [NUM_TESTS];
    logic [63:0] t_satp  [NUM_TESTS];
    logic [63:0] t_padd  [NUM_TESTS];
    logic [7:0]  t_perm  [NUM_TESTS];
    logic        t_fault [NUM_TESTS];
    int          t_reads [NUM_TESTS];
    logic        t_fence [NUM_TESTS];  // strobe sfence.vma before the request

    mmu_tlb u_dut (
        .clk(clk), .rst(rst), .rqst(rqst), .vadd(vadd), .satp(satp), .resp(resp), .perm(perm),
        .padd(padd), .fault(fault), .fence(fence), .mem_req(mem_req), .mem_addr(mem_addr),
        .mem_resp(mem_resp), .mem_rdata(mem_rdata)
    );

    mmu_checker u_chk (
        .clk(clk), .rst(rst), .rqst(rqst), .resp(resp), .perm(perm), .padd(padd),
        .fault(fault), .mem_req(mem_req)
    );

    // fixed Sv39 table, root 0x8000_0000, level 1 at 0x8000_1000, level 0 at 0x8000_2000
    function automatic logic [63:0] pte_at(input logic [63:0] addr);
        logic [63:0] idx;
        logic [7:0]  flags;
        idx   = (addr - 64'h8000_2000) >> 3;
        flags = idx[0] ? 8'h4b : 8'hcf;
        if (addr == 64'h8000_0008)
            return {10'd0, 44'h80001, 2'b00, 8'h01};  // vpn2 1 points to level 1
        else if (addr == 64'h8000_1000)
            return {10'd0, 44'h80002, 2'b00, 8'h01};  // vpn1 0 points to level 0
        else if (addr == 64'h8000_1008)
            return {10'd0, 44'h00123, 2'b00, 8'hcf};  // leaf at level 1
        else if (addr >= 64'h8000_2000 && addr < 64'h8000_2050 && addr[2:0] == 3'd0)
            return {10'd0, 44'h90000 + idx[43:0], 2'b00, flags};  // pages 0 to 9
        return '0;  // invalid everywhere else
    endfunction

    task automatic add_test(input string name, input logic [63:0] va, input logic [63:0] st,
                            input logic [63:0] pa, input logic [7:0] pm, input logic flt,
                            input int rd, input logic fnc);
        t_name[n_rows]  = name;
        t_vadd[n_rows]  = va;
        t_satp[n_rows]  = st;
        t_padd[n_rows]  = pa;
        t_perm[n_rows]  = pm;
        t_fault[n_rows] = flt;
        t_reads[n_rows] = rd;
        t_fence[n_rows] = fnc;
        n_rows++;
    endtask

    task automatic build_table();
        add_test("walk_p0", 64'h4000_0123, SATP_SV39, 64'h9000_0123, 8'hcf, 1'b0, 3, 1'b0);
        add_test("hit_p0", 64'h4000_0abc, SATP_SV39, 64'h9000_0abc, 8'hcf, 1'b0, 0, 1'b0);
        add_test("invalid_pte", 64'h4000_a010, SATP_SV39, '0, '0, 1'b1, 3, 1'b0);
        add_test("leaf_level1", 64'h4020_0000, SATP_SV39, '0, '0, 1'b1, 2, 1'b0);
        add_test("bad_satp", 64'h4000_1000, SATP_BARE, '0, '0, 1'b1, 0, 1'b0);
        add_test("fence_p0", 64'h4000_0004, SATP_SV39, 64'h9000_0004, 8'hcf, 1'b0, 3, 1'b1);
        add_test("hit_after_fence", 64'h4000_0008, SATP_SV39, 64'h9000_0008, 8'hcf,
                 1'b0, 0, 1'b0);
        for (int k = 1; k <= 8; k++) begin  // fills every slot, p8 evicts p0
            add_test($sformatf("walk_p%0d", k), 64'h4000_0000 + 64'(k * 'h1111), SATP_SV39,
                     64'h9000_0000 + 64'(k * 'h1111), k[0] ? 8'h4b : 8'hcf, 1'b0, 3, 1'b0);
        end
        add_test("evicted_p0", 64'h4000_0777, SATP_SV39, 64'h9000_0777, 8'hcf, 1'b0, 3, 1'b0);
        add_test("hit_p8", 64'h4000_8001, SATP_SV39, 64'h9000_8001, 8'hcf, 1'b0, 0, 1'b0);
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // page table memory, 1 to 4 cycles of latency
    initial begin
        mem_resp  <= 1'b0;
        mem_rdata <= '0;
        forever begin
            @(posedge clk);
            mem_resp <= 1'b0;
            if (mem_req) begin
                mem_base = mem_addr;
                mem_wait = {$random(seed)} % 4;
                repeat (mem_wait) @(posedge clk);
                @(posedge clk);
                mem_resp  <= 1'b1;
                mem_rdata <= pte_at(mem_base);
            end
        end
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Verification failed");
        $finish;
    end

    initial begin
        rst   <= 1'b1;
        rqst  <= '0;
        vadd  <= '0;
        satp  <= '0;
        fence <= 1'b0;
        build_table();
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        for (int i = 0; i < NUM_TESTS; i++) begin
            if (t_fence[i]) begin
                fence <= 1'b1;
                @(posedge clk);
                fence <= 1'b0;
                @(posedge clk);
            end
            u_chk.expect_test(t_name[i], 8'(i + 1), t_padd[i], t_perm[i], t_fault[i],
                              t_reads[i]);
            rqst <= 8'(i + 1);  // ID 0 means no request
            vadd <= t_vadd[i];
            satp <= t_satp[i];
            @(posedge clk);
            rqst <= '0;
            @(posedge clk);
            while (resp == '0) @(posedge clk);
            @(posedge clk);  // gap so the checker sees this response first
        end
        u_chk.report_counts();
        if (u_chk.checked != NUM_TESTS)
            $display("only %0d of %0d responses were checked", u_chk.checked, NUM_TESTS);
        if (u_chk.fail_count == 0 && u_chk.checked == NUM_TESTS) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+rtl
rtl/mmu_pkg.sv
rtl/tlb_lookup_stage.sv
rtl/tlb_entry.sv
rtl/tlb_response_merge.sv
rtl/page_table_walker.sv
rtl/mmu_tlb.sv
sim/mmu_checker.sv
sim/tb_mmu.sv

//--- Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_mmu \
		-f sources.f -Mdir obj_dir -o sim_mmu

run: compile
	@out="$$(./obj_dir/sim_mmu)"; echo "$$out"; \
		echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir
